//--- hw/snd_cfg_pkg.sv
// ============================================================
// register map of the host byte bus
// configuration structs handed from the register block
// to the saw voice and the square tone channel
// ============================================================
`default_nettype none

package snd_cfg_pkg;

    // register-address opcodes, written through the pointer
    typedef enum logic [7:0] {
        SAW_INC_LO = 8'h00,  // phase increment, low byte
        SAW_INC_HI = 8'h01,  // phase increment, high byte
        SAW_GAIN   = 8'h02,
        SAW_CTRL   = 8'h03,  // bit0 pan left, bit1 pan right, bit2 key-on
        SQR_PER_LO = 8'h10,
        SQR_PER_HI = 8'h11,  // low nibble only
        SQR_LEVEL  = 8'h12,  // low nibble only
        SQR_CTRL   = 8'h13   // bit0 enable
    } snd_reg_e;

    // saw voice settings
    typedef struct packed {
        logic [15:0] inc;    // added to the phase every tick
        logic [7:0]  gain;   // unsigned scale
        logic        pan_l;
        logic        pan_r;
        logic        key_on;
    } saw_cfg_t;

    // square tone settings
    typedef struct packed {
        logic [11:0] period;  // ticks per half cycle, 0 acts as 1
        logic [3:0]  level;
        logic        enable;
    } sqr_cfg_t;

endpackage

`default_nettype wire

//--- hw/snd_sample_pkg.sv
// ============================================================
// sample width and saturation bounds
// sample struct passed from the sources to the mixer
// ============================================================
`default_nettype none

package snd_sample_pkg;

    localparam int SAMPLE_W = 16;

    // clamp limits for the mixed output
    localparam int SAMPLE_MAX = 32767;
    localparam int SAMPLE_MIN = -32768;

    // one sample from a source, valid pulses for a single clock
    typedef struct packed {
        logic                       valid;
        logic signed [SAMPLE_W-1:0] value;
    } sample_t;

endpackage

`default_nettype wire

//--- hw/snd_regs.sv
// ============================================================
// host bus decode and register storage
// pointer / data write scheme, combinational readback
// sample divider turning cen into the tick strobe
// ============================================================
`default_nettype none

module snd_regs
    import snd_cfg_pkg::*;
#(
    parameter int SAMPLE_DIV = 16
) (
    input  wire logic       clk,
    input  wire logic       reset,
    input  wire logic       cen,
    input  wire logic [7:0] din,
    input  wire logic [1:0] addr,     // addr[1] reserved
    input  wire logic       cs_n,
    input  wire logic       wr_n,
    output logic      [7:0] dout,
    output saw_cfg_t        saw_cfg,
    output sqr_cfg_t        sqr_cfg,
    output logic            tick
);

    localparam int CNT_W = $clog2(SAMPLE_DIV);

    logic             write;
    logic [7:0]       ptr;       // register pointer
    logic [7:0]       rd_data;
    saw_cfg_t         saw_q;
    sqr_cfg_t         sqr_q;
    logic [CNT_W-1:0] div_cnt;

    assign write = !cs_n && !wr_n;

    // addr[0] low selects the pointer, high the data port
    always_ff @(posedge clk) begin
        if (reset) begin
            ptr   <= '0;
            saw_q <= '0;
            sqr_q <= '0;
        end else if (write) begin
            if (!addr[0]) begin
                ptr <= din;
            end else begin
                case (ptr)
                    SAW_INC_LO: saw_q.inc[7:0]     <= din;
                    SAW_INC_HI: saw_q.inc[15:8]    <= din;
                    SAW_GAIN:   saw_q.gain         <= din;
                    SAW_CTRL: begin
                        saw_q.pan_l  <= din[0];
                        saw_q.pan_r  <= din[1];
                        saw_q.key_on <= din[2];
                    end
                    SQR_PER_LO: sqr_q.period[7:0]  <= din;
                    SQR_PER_HI: sqr_q.period[11:8] <= din[3:0];
                    SQR_LEVEL:  sqr_q.level        <= din[3:0];
                    SQR_CTRL:   sqr_q.enable       <= din[0];
                    default: ;                      // unmapped, dropped
                endcase
            end
        end
    end

    // readback of the pointed register, unused bits as zero
    always_comb begin
        rd_data = 8'h00;
        case (ptr)
            SAW_INC_LO: rd_data = saw_q.inc[7:0];
            SAW_INC_HI: rd_data = saw_q.inc[15:8];
            SAW_GAIN:   rd_data = saw_q.gain;
            SAW_CTRL:   rd_data = {5'd0, saw_q.key_on, saw_q.pan_r, saw_q.pan_l};
            SQR_PER_LO: rd_data = sqr_q.period[7:0];
            SQR_PER_HI: rd_data = {4'd0, sqr_q.period[11:8]};
            SQR_LEVEL:  rd_data = {4'd0, sqr_q.level};
            SQR_CTRL:   rd_data = {7'd0, sqr_q.enable};
            default:    rd_data = 8'h00;
        endcase
    end

    assign dout = addr[0] ? rd_data : ptr;

    assign saw_cfg = saw_q;
    assign sqr_cfg = sqr_q;

    // sample divider, only counts enabled clocks
    always_ff @(posedge clk) begin
        if (reset) begin
            div_cnt <= '0;
            tick    <= 1'b0;
        end else begin
            tick <= 1'b0;
            if (cen) begin
                if (div_cnt == CNT_W'(SAMPLE_DIV - 1)) begin
                    div_cnt <= '0;
                    tick    <= 1'b1;   // one pulse per wrap
                end else begin
                    div_cnt <= div_cnt + 1'b1;
                end
            end
        end
    end

endmodule

`default_nettype wire

//--- hw/saw_voice.sv
// ============================================================
// sawtooth voice
// 16-bit phase accumulator stepped on tick
// centred top byte scaled by the gain
// phase held at zero while keyed off
// ============================================================
`default_nettype none

module saw_voice
    import snd_cfg_pkg::*;
    import snd_sample_pkg::*;
(
    input  wire logic     clk,
    input  wire logic     reset,
    input  wire logic     tick,
    input  wire saw_cfg_t cfg,
    output sample_t       sample
);

    logic        [15:0] phase;
    logic        [15:0] phase_nxt;
    logic signed [8:0]  centred;     // -128 .. 127
    logic signed [8:0]  gain_s;
    logic signed [17:0] scaled;

    assign phase_nxt = phase + cfg.inc;   // wraps at 16 bits

    // output uses the phase after the add
    assign centred = $signed({1'b0, phase_nxt[15:8]}) - 9'sd128;
    assign gain_s  = $signed({1'b0, cfg.gain});

    // worst case 128 * 255 still fits in 16 bits signed
    assign scaled = centred * gain_s;

    always_ff @(posedge clk) begin
        if (reset) begin
            phase        <= '0;
            sample.valid <= 1'b0;
        end else begin
            sample.valid <= tick;
            if (tick) begin
                if (cfg.key_on) begin
                    phase        <= phase_nxt;
                    sample.value <= scaled[SAMPLE_W-1:0];
                end else begin
                    phase        <= '0;        // restart on next key-on
                    sample.value <= '0;
                end
            end
        end
    end

endmodule

`default_nettype wire

//--- hw/square_tone.sv
// ============================================================
// square tone channel
// tick counter up to the effective period
// polarity toggle and signed level * 1024 output
// ============================================================
`default_nettype none

module square_tone
    import snd_cfg_pkg::*;
    import snd_sample_pkg::*;
(
    input  wire logic     clk,
    input  wire logic     reset,
    input  wire logic     tick,
    input  wire sqr_cfg_t cfg,
    output sample_t       sample
);

    logic        [11:0]         cnt;
    logic        [11:0]         cnt_nxt;
    logic        [11:0]         eff_period;
    logic                       pol;        // high gives the positive half
    logic                       pol_nxt;
    logic                       wrap;
    logic signed [SAMPLE_W-1:0] mag;

    // a period of 0 behaves like 1
    assign eff_period = (cfg.period == 12'd0) ? 12'd1 : cfg.period;

    assign cnt_nxt = cnt + 1'b1;
    assign wrap    = (cnt_nxt == eff_period);
    assign pol_nxt = wrap ? !pol : pol;

    assign mag = $signed({2'b00, cfg.level, 10'd0});   // level * 1024

    always_ff @(posedge clk) begin
        if (reset) begin
            cnt          <= '0;
            pol          <= 1'b0;
            sample.valid <= 1'b0;
        end else begin
            sample.valid <= tick;
            if (tick) begin
                if (cfg.enable) begin
                    cnt <= wrap ? 12'd0 : cnt_nxt;
                    pol <= pol_nxt;
                    // sign follows the polarity after this step
                    sample.value <= pol_nxt ? mag : -mag;
                end else begin
                    cnt          <= '0;
                    pol          <= 1'b0;
                    sample.value <= '0;
                end
            end
        end
    end

endmodule

`default_nettype wire

//--- hw/snd_mixer.sv
// ============================================================
// stereo mixer
// pan gated saw plus square on each side
// 16-bit saturation and the snd_sample strobe
// ============================================================
`default_nettype none

module snd_mixer
    import snd_sample_pkg::*;
(
    input  wire logic                  clk,
    input  wire logic                  reset,
    input  wire sample_t               saw,
    input  wire sample_t               sqr,
    input  wire logic                  pan_l,
    input  wire logic                  pan_r,
    output logic signed [SAMPLE_W-1:0] snd_left,
    output logic signed [SAMPLE_W-1:0] snd_right,
    output logic                       snd_sample
);

    localparam int SUM_W = SAMPLE_W + 2;   // headroom for the sum

    logic signed [SUM_W-1:0] saw_w;
    logic signed [SUM_W-1:0] sqr_w;
    logic signed [SUM_W-1:0] saw_l;
    logic signed [SUM_W-1:0] saw_r;
    logic signed [SUM_W-1:0] sum_l;
    logic signed [SUM_W-1:0] sum_r;

    function automatic logic signed [SAMPLE_W-1:0] clamp(input logic signed [SUM_W-1:0] x);
        if (x > SAMPLE_MAX)
            return SAMPLE_W'(SAMPLE_MAX);
        else if (x < SAMPLE_MIN)
            return SAMPLE_W'(SAMPLE_MIN);
        else
            return x[SAMPLE_W-1:0];
    endfunction

    // sign extension to the wide width
    assign saw_w = saw.value;
    assign sqr_w = sqr.value;

    assign saw_l = saw_w & {SUM_W{pan_l}};
    assign saw_r = saw_w & {SUM_W{pan_r}};

    // square channel is centre panned
    assign sum_l = saw_l + sqr_w;
    assign sum_r = saw_r + sqr_w;

    // both sources step on the same tick so saw valid marks them both
    always_ff @(posedge clk) begin
        if (reset) begin
            snd_left   <= '0;
            snd_right  <= '0;
            snd_sample <= 1'b0;
        end else begin
            snd_sample <= saw.valid;
            if (saw.valid) begin
                snd_left  <= clamp(sum_l);
                snd_right <= clamp(sum_r);
            end
        end
    end

endmodule

`default_nettype wire

//--- hw/snd_top.sv
// ============================================================
// two-voice sound generator top level
// register block, saw voice, square tone and mixer
// ============================================================
`default_nettype none

module snd_top
    import snd_cfg_pkg::*;
    import snd_sample_pkg::*;
#(
    parameter int SAMPLE_DIV = 16   // enabled clocks per sample, 4 or more
) (
    input  wire logic                  clk,
    input  wire logic                  reset,
    input  wire logic                  cen,
    input  wire logic [7:0]            din,
    input  wire logic [1:0]            addr,
    input  wire logic                  cs_n,
    input  wire logic                  wr_n,
    output logic      [7:0]            dout,
    output logic signed [SAMPLE_W-1:0] snd_left,
    output logic signed [SAMPLE_W-1:0] snd_right,
    output logic                       snd_sample
);

    saw_cfg_t saw_cfg;
    sqr_cfg_t sqr_cfg;
    logic     tick;
    sample_t  saw_smp;
    sample_t  sqr_smp;

    snd_regs #(
        .SAMPLE_DIV ( SAMPLE_DIV )
    ) i_snd_regs (
        .clk     ( clk     ),
        .reset   ( reset   ),
        .cen     ( cen     ),
        .din     ( din     ),
        .addr    ( addr    ),
        .cs_n    ( cs_n    ),
        .wr_n    ( wr_n    ),
        .dout    ( dout    ),
        .saw_cfg ( saw_cfg ),
        .sqr_cfg ( sqr_cfg ),
        .tick    ( tick    )
    );

    saw_voice i_saw_voice (
        .clk    ( clk     ),
        .reset  ( reset   ),
        .tick   ( tick    ),
        .cfg    ( saw_cfg ),
        .sample ( saw_smp )
    );

    square_tone i_square_tone (
        .clk    ( clk     ),
        .reset  ( reset   ),
        .tick   ( tick    ),
        .cfg    ( sqr_cfg ),
        .sample ( sqr_smp )
    );

    // pan applies to the saw voice only
    snd_mixer i_snd_mixer (
        .clk        ( clk           ),
        .reset      ( reset         ),
        .saw        ( saw_smp       ),
        .sqr        ( sqr_smp       ),
        .pan_l      ( saw_cfg.pan_l ),
        .pan_r      ( saw_cfg.pan_r ),
        .snd_left   ( snd_left      ),
        .snd_right  ( snd_right     ),
        .snd_sample ( snd_sample    )
    );

endmodule

`default_nettype wire

//--- tb/snd_tb.sv
// ============================================================
// testbench for the two-voice sound generator
// host bus tasks, xorshift stimulus, per-sample reference model
// concurrent checks on samples, readback, reset and timing
// watchdog and closing status line
// ============================================================
`default_nettype none

module snd_tb
    import snd_cfg_pkg::*;
    import snd_sample_pkg::*;
();

    timeunit 1ns;
    timeprecision 1ps;

    localparam int SAMPLE_DIV = 16;
    localparam int CLK_NS     = 100;
    localparam int N_IDLE     = 8;
    localparam int N_SAW      = 25;
    localparam int N_SQR      = 20;
    localparam int N_MIX      = 30;
    // extra 40 samples cover the bus phases and the cen stretch
    localparam int TEST_SAMPLES = N_IDLE + 4 * N_SAW + 4 * N_SQR + 4 * N_MIX + 40;
    localparam int TIMEOUT_NS   = TEST_SAMPLES * SAMPLE_DIV * CLK_NS * 2;

    logic                       clk = 1'b0;
    logic                       reset;
    logic                       cen;
    logic [7:0]                 din;
    logic [1:0]                 addr;
    logic                       cs_n;
    logic                       wr_n;
    logic [7:0]                 dout;
    logic signed [SAMPLE_W-1:0] snd_left;
    logic signed [SAMPLE_W-1:0] snd_right;
    logic                       snd_sample;

    // register image kept by the bus tasks with unused bits masked
    logic [7:0]  shadow [256] = '{default: 8'h00};
    logic [7:0]  mapped [8] = '{SAW_INC_LO, SAW_INC_HI, SAW_GAIN, SAW_CTRL,
                                SQR_PER_LO, SQR_PER_HI, SQR_LEVEL, SQR_CTRL};
    logic [31:0] seed = 32'hc3630056;

    // reference model state
    logic [15:0]                phase_m = '0;
    logic [11:0]                cnt_m = '0;
    logic                       pol_m = 1'b0;
    logic signed [SAMPLE_W-1:0] exp_left = '0;
    logic signed [SAMPLE_W-1:0] exp_right = '0;
    logic                       chk = 1'b0;      // model has a fresh sample to compare
    logic                       model_on = 1'b1;
    logic                       rd_chk = 1'b0;
    logic [7:0]                 rd_exp = '0;
    logic                       rst_seen = 1'b0;
    int                         errors = 0;
    int                         n_samples = 0;
    int                         n_reads = 0;
    int                         hits_max = 0;
    int                         hits_min = 0;

    snd_top #(
        .SAMPLE_DIV ( SAMPLE_DIV )
    ) i_snd_top (
        .clk        ( clk        ),
        .reset      ( reset      ),
        .cen        ( cen        ),
        .din        ( din        ),
        .addr       ( addr       ),
        .cs_n       ( cs_n       ),
        .wr_n       ( wr_n       ),
        .dout       ( dout       ),
        .snd_left   ( snd_left   ),
        .snd_right  ( snd_right  ),
        .snd_sample ( snd_sample )
    );

    initial begin
        forever #(CLK_NS / 2) clk = ~clk;
    end

    always @(posedge clk) rst_seen <= reset;

    function automatic logic [31:0] xorshift(input logic [31:0] s);
        logic [31:0] x;
        x = s;
        x = x ^ (x << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        return x;
    endfunction

    function automatic logic [31:0] next_random();
        seed = xorshift(seed);
        return seed;
    endfunction

    // bits each register keeps
    function automatic logic [7:0] reg_mask(input logic [7:0] a);
        case (a)
            SAW_INC_LO, SAW_INC_HI, SAW_GAIN, SQR_PER_LO: return 8'hff;
            SAW_CTRL:              return 8'h07;
            SQR_PER_HI, SQR_LEVEL: return 8'h0f;
            SQR_CTRL:              return 8'h01;
            default:               return 8'h00;
        endcase
    endfunction

    // clamp hits only count for samples that get compared
    function automatic logic signed [SAMPLE_W-1:0] saturate(input int x);
        if (x > SAMPLE_MAX) begin
            if (model_on)
                hits_max++;
            return SAMPLE_W'(SAMPLE_MAX);
        end
        if (x < SAMPLE_MIN) begin
            if (model_on)
                hits_min++;
            return SAMPLE_W'(SAMPLE_MIN);
        end
        return SAMPLE_W'(x);
    endfunction

    // one sample of both sources and the mixer
    task automatic step_model();
        logic [11:0] per;
        int          saw_v;
        int          sqr_v;
        int          mag;
        if (shadow[SAW_CTRL][2]) begin
            phase_m = phase_m + {shadow[SAW_INC_HI], shadow[SAW_INC_LO]};
            saw_v = (int'(phase_m[15:8]) - 128) * int'(shadow[SAW_GAIN]);
        end else begin
            phase_m = '0;
            saw_v = 0;
        end
        per = {shadow[SQR_PER_HI][3:0], shadow[SQR_PER_LO]};
        if (per == 12'd0)
            per = 12'd1;
        if (shadow[SQR_CTRL][0]) begin
            cnt_m = cnt_m + 1'b1;
            if (cnt_m == per) begin
                cnt_m = '0;
                pol_m = !pol_m;
            end
            mag = int'(shadow[SQR_LEVEL][3:0]) * 1024;
            sqr_v = pol_m ? mag : -mag;
        end else begin
            cnt_m = '0;
            pol_m = 1'b0;
            sqr_v = 0;
        end
        exp_left  = saturate((shadow[SAW_CTRL][0] ? saw_v : 0) + sqr_v);
        exp_right = saturate((shadow[SAW_CTRL][1] ? saw_v : 0) + sqr_v);
    endtask

    // outputs are stable at the falling edge of the pulse
    always @(negedge clk) begin
        chk = 1'b0;
        if (!reset && snd_sample) begin
            step_model();
            n_samples++;
            chk = 1'b1;
        end
    end

    task automatic drive_write(input logic a0, input logic [7:0] d);
        @(negedge clk);
        addr = {1'b0, a0};
        din  = d;
        cs_n = 1'b0;
        wr_n = 1'b0;
        @(posedge clk);
    endtask

    task automatic release_bus();
        @(negedge clk);
        cs_n = 1'b1;
        wr_n = 1'b1;
    endtask

    task automatic write_reg(input logic [7:0] a, input logic [7:0] v);
        drive_write(1'b0, a);
        drive_write(1'b1, v);
        shadow[a] = v & reg_mask(a);
    endtask

    task automatic read_and_check(input logic a0, input logic [7:0] expected);
        @(negedge clk);
        addr   = {1'b0, a0};
        cs_n   = 1'b0;
        wr_n   = 1'b1;
        rd_exp = expected;
        rd_chk = 1'b1;
        n_reads++;
        @(negedge clk);
        rd_chk = 1'b0;
        cs_n   = 1'b1;
    endtask

    task automatic wait_samples(input int n);
        repeat (n) @(posedge clk iff snd_sample);
    endtask

    check_sample: assert property (@(posedge clk) chk && model_on |->
            snd_left == exp_left && snd_right == exp_right)
        else begin
            errors++;
            $display("** Error %0t: left %0d expected %0d, right %0d expected %0d",
                $time, $sampled(snd_left), exp_left, $sampled(snd_right), exp_right);
        end

    check_read: assert property (@(posedge clk) rd_chk |-> dout == rd_exp)
        else begin
            errors++;
            $display("** Error %0t: dout %h expected %h", $time, $sampled(dout), rd_exp);
        end

    check_reset: assert property (@(posedge clk) rst_seen && reset |-> !snd_sample)
        else begin
            errors++;
            $display("** Error %0t: snd_sample high during reset", $time);
        end

    check_period: assert property (@(posedge clk) disable iff (reset || !cen)
            snd_sample |=> !snd_sample [*SAMPLE_DIV-1] ##1 snd_sample)
        else begin
            errors++;
            $display("** Error %0t: snd_sample spacing is not %0d clocks", $time, SAMPLE_DIV);
        end

    check_hold: assert property (@(posedge clk) disable iff (reset) !cen |-> !snd_sample)
        else begin
            errors++;
            $display("** Error %0t: snd_sample pulsed while cen was low", $time);
        end

    initial begin
        #(TIMEOUT_NS);
        $display("run timed out after %0d ns, errors so far %0d", TIMEOUT_NS, errors);
        $display("STATUS: FAIL");
        $finish;
    end

    initial begin
        logic [31:0] r;
        logic [7:0]  a;
        $timeformat(-9, 0, " ns", 0);
        reset = 1'b1;
        cen   = 1'b1;
        din   = 8'h00;
        addr  = 2'b00;
        cs_n  = 1'b1;
        wr_n  = 1'b1;
        repeat (2) @(posedge clk);
        @(negedge clk);
        reset = 1'b0;

        wait_samples(N_IDLE);   // all registers zero so outputs stay silent

        // readback check while the model is out of sync
        model_on = 1'b0;
        repeat (20) begin
            r = next_random();
            a = mapped[r[2:0]];
            write_reg(a, r[15:8]);
            read_and_check(1'b1, shadow[a]);
            read_and_check(1'b0, a);
        end
        wait_samples(1);
        write_reg(SAW_CTRL, 8'h00);
        write_reg(SQR_CTRL, 8'h00);
        release_bus();
        wait_samples(2);        // phase and counter back at zero
        model_on = 1'b1;

        // saw voice alone panned left
        repeat (2) begin
            r = next_random();
            write_reg(SAW_INC_LO, r[7:0]);
            write_reg(SAW_INC_HI, r[15:8]);
            write_reg(SAW_GAIN, r[23:16]);
            write_reg(SAW_CTRL, 8'h05);
            release_bus();
            wait_samples(N_SAW);
            write_reg(SAW_CTRL, 8'h01);   // key off
            release_bus();
            wait_samples(2);
            write_reg(SAW_CTRL, 8'h05);
            release_bus();
            wait_samples(N_SAW);
        end
        write_reg(SAW_CTRL, 8'h00);
        release_bus();
        wait_samples(1);

        // square tone alone starting with period 0
        for (int i = 0; i < 4; i++) begin
            r = next_random();
            write_reg(SQR_CTRL, 8'h00);
            release_bus();
            wait_samples(1);
            write_reg(SQR_PER_LO, (i == 0) ? 8'h00 : {5'd0, r[2:0]});
            write_reg(SQR_PER_HI, {r[7:4], 4'h0});   // upper nibble not stored
            write_reg(SQR_LEVEL, r[15:8] | 8'h01);
            write_reg(SQR_CTRL, 8'h01);
            release_bus();
            wait_samples(N_SQR);
        end

        // full scale on both sources over all pan settings
        r = next_random();
        write_reg(SAW_INC_LO, r[7:0]);
        write_reg(SAW_INC_HI, 8'h05);
        write_reg(SAW_GAIN, 8'hff);
        write_reg(SQR_PER_LO, 8'h03);
        write_reg(SQR_LEVEL, 8'h0f);
        release_bus();
        wait_samples(1);
        for (int p = 0; p < 4; p++) begin
            write_reg(SAW_CTRL, 8'h04 | 8'(p));
            write_reg(SQR_CTRL, 8'h01);
            release_bus();
            wait_samples(N_MIX);
        end

        // cen held low right after a pulse
        wait_samples(4);
        @(negedge clk);
        cen = 1'b0;
        repeat (40) @(negedge clk);
        cen = 1'b1;
        wait_samples(4);

        if (hits_max == 0 || hits_min == 0) begin
            errors++;
            $display("mixer output never reached both saturation bounds");
        end
        $display("samples %0d, reads %0d, errors %0d", n_samples, n_reads, errors);
        if (errors == 0)
            $display("STATUS: PASS");
        else
            $display("STATUS: FAIL");
        $finish;
    end

endmodule

`default_nettype wire

//--- list.f
hw/snd_cfg_pkg.sv
hw/snd_sample_pkg.sv
hw/snd_regs.sv
hw/saw_voice.sv
hw/square_tone.sv
hw/snd_mixer.sv
hw/snd_top.sv
tb/snd_tb.sv

//--- Bender.yml
package:
  name: snd_gen

sources:
  # packages first, then the design from the leaves up
  - hw/snd_cfg_pkg.sv
  - hw/snd_sample_pkg.sv
  - hw/snd_regs.sv
  - hw/saw_voice.sv
  - hw/square_tone.sv
  - hw/snd_mixer.sv
  - hw/snd_top.sv

  - target: test
    files:
      - tb/snd_tb.sv
